/* tb/fetch_testdata.txt */
# columns in hex: command, operand a, operand b, expected value
# WRITE addr data echo | RUN cycles | BR/JR base offset target | JI base offset unused
WRITE 0000 1000 1000
WRITE 0002 1011 1011
WRITE 0004 1022 1022
WRITE 0006 1033 1033
WRITE 0008 1044 1044
WRITE 000a 1055 1055
WRITE 000c 1066 1066
WRITE 000e 1077 1077
WRITE 0010 1088 1088
WRITE 0012 1099 1099
WRITE 0014 10aa 10aa
WRITE 0016 10bb 10bb
WRITE 0018 10cc 10cc
WRITE 001a 10dd 10dd
WRITE 001c 10ee 10ee
WRITE 001e 10ff 10ff
WRITE 0040 2040 2040
WRITE 0042 2042 2042
RUN 0030 0000 0000
BR 0000 0004 0004
RUN 0010 0000 0000
BR 0000 0000 0000
HAZ 0000 0000 0000
NOP 0000 0000 0000
HALT 0000 0000 0000
RUN 0004 0000 0000
JI 0000 0006 0000
RUN 0010 0000 0000
JR 0001 0002 0003
RUN 0003 0000 0000
BR 0000 0014 0014
RUN 0004 0000 0000
JR 0000 0040 0040
WRITE 0100 beef beef
RUN 0002 0000 0000
BR 0010 0004 0014
RUN 0006 0000 0000

/* sources.f */
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_stage.sv
verilog/icache.sv
verilog/mem_arbiter.sv
verilog/main_mem.sv
verilog/fetch_top.sv
tb/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_stage.sv
      - verilog/icache.sv
      - verilog/mem_arbiter.sv
      - verilog/main_mem.sv
      - verilog/fetch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/fetch_tb.sv

/* tb/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defines.svh"

module fetch_tb;

   // one cycle each to enter refill, to win arbitration and to hit, plus the memory latency
   localparam int refill_bound = 2 * (3 + `FETCH_MEM_LAT);

   logic                  clk;
   logic                  rst_n;
   logic                  hazard;
   logic                  nop_req;
   logic                  halt;
   fetch_pkg::redirect_t  redirect;
   fetch_pkg::mem_req_t   data_req;
   fetch_pkg::mem_rsp_t   data_rsp;
   fetch_pkg::fetch_out_t fetch_out;
   logic [15:0]           pc;

   // reference state for memory, pc and which cache lines are known to hold a word
   logic [15:0]         mem_model [1024];
   logic [15:0]         model_pc;
   logic [15:0]         line_valid;
   logic [10:0]         line_tag [16];
   fetch_pkg::mem_req_t wr_req;
   int                  stall_run;
   logic [15:0]         stall_pc;
   int                  errors;
   int                  cycles;
   int                  limit;

   fetch_top dut_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .hazard    (hazard),
      .nop_req   (nop_req),
      .halt      (halt),
      .redirect  (redirect),
      .data_req  (data_req),
      .data_rsp  (data_rsp),
      .fetch_out (fetch_out),
      .pc        (pc)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("Some tests failed");
         $finish;
      end
   end

   task automatic check_fetch(input fetch_pkg::fetch_out_t exp, input fetch_pkg::fetch_out_t act);
      if (act !== exp) begin
         errors = errors + 1;
         $display("FAILED t=%0t fetch_out exp=%h act=%h", $time, exp, act);
      end
   endtask

   task automatic check_pc(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) begin
         errors = errors + 1;
         $display("FAILED t=%0t %s exp=%h act=%h", $time, name, exp, act);
      end
   endtask

   task automatic check_rsp(input fetch_pkg::mem_rsp_t exp, input fetch_pkg::mem_rsp_t act);
      if (act !== exp) begin
         errors = errors + 1;
         $display("FAILED t=%0t data_rsp exp=%h act=%h", $time, exp, act);
      end
   endtask

   // drives one clock of inputs and checks the outputs at the falling edge
   task automatic run_step(input logic haz, input logic nop, input logic hlt,
                           input fetch_pkg::redirect_t rd, input logic [15:0] target,
                           output logic done);
      fetch_pkg::fetch_out_t exp;
      logic [3:0]            idx;
      logic                  known;
      logic                  stall;
      @(posedge clk);
      #10;
      hazard   = haz;
      nop_req  = nop;
      halt     = hlt;
      redirect = rd;
      data_req = wr_req;
      @(negedge clk);
      check_pc("pc", model_pc, pc);
      idx   = model_pc[4:1];
      known = line_valid[idx] && (line_tag[idx] == model_pc[15:5]);
      if (model_pc[0]) begin
         stall = 1'b0;
      end else if (nop) begin
         stall = ~known;
      end else begin
         stall = (fetch_out.instr === `FETCH_NOP);
      end
      if (!model_pc[0] && !nop && known && stall) begin
         errors = errors + 1;
         $display("stall seen at t=%0t on address %h that is already cached", $time, model_pc);
      end
      // a stall at one pc ends within two refills unless a data write holds the memory
      if (!stall || wr_req.valid) begin
         stall_run = 0;
      end else if (model_pc == stall_pc) begin
         stall_run = stall_run + 1;
      end else begin
         stall_run = 1;
      end
      stall_pc = model_pc;
      if (stall_run > refill_bound) begin
         errors = errors + 1;
         $display("refill of address %h did not finish within %0d cycles at t=%0t",
                  model_pc, refill_bound, $time);
         stall_run = 0;
      end
      exp.instr     = (nop || stall || model_pc[0]) ? `FETCH_NOP : mem_model[model_pc[10:1]];
      exp.pc_plus2  = model_pc + 16'd2;
      exp.align_err = model_pc[0];
      check_fetch(exp, fetch_out);
      // a miss means this line is being replaced
      if (!model_pc[0] && !nop) begin
         line_valid[idx] = ~stall;
         line_tag[idx]   = model_pc[15:5];
      end
      done = data_rsp.done;
      if (hlt) begin
         model_pc = model_pc;
      end else if (rd.kind == fetch_pkg::REDIR_JUMP_IMM) begin
         model_pc = model_pc + 16'd2 + rd.offset;
      end else if (rd.kind != fetch_pkg::REDIR_NONE) begin
         model_pc = target;
      end else if (!(haz || stall)) begin
         model_pc = model_pc + 16'd2;
      end
   endtask

   initial begin
      int                   fd;
      int                   code;
      int                   steps;
      string                cmd;
      string                line;
      logic [15:0]          a;
      logic [15:0]          b;
      logic [15:0]          e;
      logic                 done;
      fetch_pkg::redirect_t idle_rd;
      fetch_pkg::redirect_t rd;
      fetch_pkg::mem_rsp_t  exp_rsp;
      string                cmd_q [$];
      logic [15:0]          a_q [$];
      logic [15:0]          b_q [$];
      logic [15:0]          e_q [$];

      clk      = 1'b0;
      rst_n    = 1'b0;
      hazard   = 1'b0;
      nop_req  = 1'b0;
      halt     = 1'b0;
      idle_rd  = '0;
      redirect = idle_rd;
      wr_req   = '0;
      data_req = '0;
      errors   = 0;
      cycles   = 0;
      limit    = 0;
      steps    = 0;
      stall_run  = 0;
      stall_pc   = '0;
      model_pc   = '0;
      line_valid = '0;
      for (int i = 0; i < 1024; i++) begin
         mem_model[i] = 'x;
      end

      fd = $fopen("tb/fetch_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open tb/fetch_testdata.txt");
         $display("Some tests failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1) begin
               break;
            end
            if (cmd[0] == "#") begin
               code = $fgets(line, fd);
               continue;
            end
            code = $fscanf(fd, "%h %h %h", a, b, e);
            cmd_q.push_back(cmd);
            a_q.push_back(a);
            b_q.push_back(b);
            e_q.push_back(e);
            steps = steps + ((cmd == "RUN") ? int'(a) : 1);
         end
         $fclose(fd);

         // worst case is a miss behind a data write
         limit = steps * 12 + 100;

         repeat (4) @(posedge clk);
         #10;
         rst_n = 1'b1;

         foreach (cmd_q[i]) begin
            rd      = idle_rd;
            rd.base   = a_q[i];
            rd.offset = b_q[i];
            case (cmd_q[i])
               "WRITE": begin
                  wr_req = '{valid: 1'b1, we: 1'b1, addr: a_q[i], wdata: b_q[i]};
                  done   = 1'b0;
                  while (!done) begin
                     run_step(1'b0, 1'b0, 1'b1, idle_rd, 16'd0, done);
                  end
                  exp_rsp = '{done: 1'b1, rdata: e_q[i]};
                  check_rsp(exp_rsp, data_rsp);
                  mem_model[a_q[i][10:1]] = b_q[i];
                  wr_req = '0;
               end
               "RUN": begin
                  for (int n = 0; n < int'(a_q[i]); n++) begin
                     run_step(1'b0, 1'b0, 1'b0, idle_rd, 16'd0, done);
                  end
               end
               "HAZ":  run_step(1'b1, 1'b0, 1'b0, idle_rd, 16'd0, done);
               "NOP":  run_step(1'b0, 1'b1, 1'b0, idle_rd, 16'd0, done);
               "HALT": run_step(1'b0, 1'b0, 1'b1, idle_rd, 16'd0, done);
               "BR", "JI", "JR": begin
                  if (cmd_q[i] == "BR") begin
                     rd.kind = fetch_pkg::REDIR_BRANCH;
                  end else if (cmd_q[i] == "JI") begin
                     rd.kind = fetch_pkg::REDIR_JUMP_IMM;
                  end else begin
                     rd.kind = fetch_pkg::REDIR_JUMP_REG;
                  end
                  run_step(1'b0, 1'b0, 1'b0, rd, e_q[i], done);
               end
               default: begin
                  errors = errors + 1;
                  $display("unknown command %s in the test data", cmd_q[i]);
               end
            endcase
         end
         run_step(1'b0, 1'b0, 1'b1, idle_rd, 16'd0, done);

         $display("checks done, %0d errors", errors);
         if (errors == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* verilog/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  hazard,
   input  logic                  nop_req,
   input  logic                  halt,
   input  fetch_pkg::redirect_t  redirect,
   input  fetch_pkg::mem_req_t   data_req,
   output fetch_pkg::mem_rsp_t   data_rsp,
   output fetch_pkg::fetch_out_t fetch_out,
   output logic [15:0]           pc
);

   logic                ic_hit;
   logic [15:0]         ic_word;
   fetch_pkg::mem_req_t refill_req;
   fetch_pkg::mem_rsp_t refill_rsp;
   fetch_pkg::mem_req_t mem_req;
   fetch_pkg::mem_rsp_t mem_rsp;

   fetch_stage fetch_stage_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .hazard    (hazard),
      .nop_req   (nop_req),
      .halt      (halt),
      .redirect  (redirect),
      .ic_hit    (ic_hit),
      .ic_word   (ic_word),
      .pc        (pc),
      .fetch_out (fetch_out)
   );

   icache icache_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pc         (pc),
      .hit        (ic_hit),
      .word       (ic_word),
      .refill_req (refill_req),
      .refill_rsp (refill_rsp)
   );

   // the memory stage data port shares memory with cache refills
   mem_arbiter mem_arbiter_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .data_req   (data_req),
      .ifetch_req (refill_req),
      .data_rsp   (data_rsp),
      .ifetch_rsp (refill_rsp),
      .mem_req    (mem_req),
      .mem_rsp    (mem_rsp)
   );

   main_mem main_mem_i (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mem_req),
      .rsp   (mem_rsp)
   );

endmodule

`default_nettype wire

/* verilog/main_mem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defines.svh"

module main_mem (
   input  logic                clk,
   input  logic                rst_n,
   input  fetch_pkg::mem_req_t req,
   output fetch_pkg::mem_rsp_t rsp
);

   localparam int addr_w = $clog2(`FETCH_MEM_WORDS);
   localparam int cnt_w  = $clog2(`FETCH_MEM_LAT + 1);

   logic [`FETCH_XLEN-1:0] mem_q [`FETCH_MEM_WORDS];
   logic [addr_w-1:0]      word_addr;
   logic [cnt_w-1:0]       cnt_q;
   logic                   done_q;
   logic [`FETCH_XLEN-1:0] rdata_q;
   logic                   last;

   // byte address to word index
   assign word_addr = req.addr[addr_w:1];

   // request stays high through the done cycle and is not counted there
   assign last = req.valid & ~done_q & (cnt_q == cnt_w'(`FETCH_MEM_LAT - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q  <= '0;
         done_q <= 1'b0;
      end else begin
         done_q <= last;
         if (last) begin
            cnt_q <= '0;
         end else if (req.valid && !done_q) begin
            cnt_q <= cnt_q + cnt_w'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (last) begin
         if (req.we) begin
            mem_q[word_addr] <= req.wdata;
         end
         rdata_q <= req.we ? req.wdata : mem_q[word_addr];
      end
   end

   always_comb begin
      rsp.done  = done_q;
      rsp.rdata = rdata_q;
   end

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
   input  logic                clk,
   input  logic                rst_n,
   input  fetch_pkg::mem_req_t data_req,
   input  fetch_pkg::mem_req_t ifetch_req,
   output fetch_pkg::mem_rsp_t data_rsp,
   output fetch_pkg::mem_rsp_t ifetch_rsp,
   output fetch_pkg::mem_req_t mem_req,
   input  fetch_pkg::mem_rsp_t mem_rsp
);

   fetch_pkg::grant_e grant_q;

   // dropping the grant to none on done gives the idle cycle
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         grant_q <= fetch_pkg::GNT_NONE;
      end else begin
         case (grant_q)
            fetch_pkg::GNT_NONE: begin
               // data port has fixed priority
               if (data_req.valid) begin
                  grant_q <= fetch_pkg::GNT_DATA;
               end else if (ifetch_req.valid) begin
                  grant_q <= fetch_pkg::GNT_IFETCH;
               end
            end
            default: begin
               if (mem_rsp.done) begin
                  grant_q <= fetch_pkg::GNT_NONE;
               end
            end
         endcase
      end
   end

   always_comb begin
      case (grant_q)
         fetch_pkg::GNT_DATA:   mem_req = data_req;
         fetch_pkg::GNT_IFETCH: mem_req = ifetch_req;
         default:               mem_req = '0;
      endcase
   end

   always_comb begin
      data_rsp.done    = mem_rsp.done & (grant_q == fetch_pkg::GNT_DATA);
      data_rsp.rdata   = mem_rsp.rdata;
      ifetch_rsp.done  = mem_rsp.done & (grant_q == fetch_pkg::GNT_IFETCH);
      ifetch_rsp.rdata = mem_rsp.rdata;
   end

   one_done: assert property (@(posedge clk) disable iff (!rst_n)
      !(data_rsp.done && ifetch_rsp.done));

endmodule

`default_nettype wire

/* verilog/icache.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defines.svh"

module icache (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [`FETCH_XLEN-1:0] pc,
   output logic                   hit,
   output logic [`FETCH_XLEN-1:0] word,
   output fetch_pkg::mem_req_t    refill_req,
   input  fetch_pkg::mem_rsp_t    refill_rsp
);

   localparam int lines = 1 << `FETCH_IDX_W;
   localparam int tag_w = `FETCH_XLEN - `FETCH_IDX_W - 1;

   fetch_pkg::ic_state_e     state_q;
   logic [tag_w-1:0]         tag_q [lines];
   logic [`FETCH_XLEN-1:0]   data_q [lines];
   logic [lines-1:0]         valid_q;
   logic [`FETCH_XLEN-1:0]   refill_addr_q;
   logic [`FETCH_IDX_W-1:0]  idx;
   logic [tag_w-1:0]         tag;
   logic [`FETCH_IDX_W-1:0]  fill_idx;
   logic [tag_w-1:0]         fill_tag;
   logic                     miss;

   // bit 0 is the byte offset within the word
   assign idx = pc[`FETCH_IDX_W:1];
   assign tag = pc[`FETCH_XLEN-1:`FETCH_IDX_W+1];

   assign fill_idx = refill_addr_q[`FETCH_IDX_W:1];
   assign fill_tag = refill_addr_q[`FETCH_XLEN-1:`FETCH_IDX_W+1];

   assign hit  = ~pc[0] & valid_q[idx] & (tag_q[idx] == tag);
   assign word = data_q[idx];
   assign miss = ~pc[0] & ~hit;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= fetch_pkg::IC_IDLE;
         valid_q <= '0;
      end else begin
         case (state_q)
            fetch_pkg::IC_IDLE: begin
               if (miss) begin
                  state_q <= fetch_pkg::IC_REFILL;
               end
            end
            default: begin
               if (refill_rsp.done) begin
                  valid_q[fill_idx] <= 1'b1;
                  state_q           <= fetch_pkg::IC_IDLE;
               end
            end
         endcase
      end
   end

   // refill address is latched so a redirect mid-refill still fills the old line
   always_ff @(posedge clk) begin
      if (state_q == fetch_pkg::IC_IDLE && miss) begin
         refill_addr_q <= pc;
      end
      if (state_q == fetch_pkg::IC_REFILL && refill_rsp.done) begin
         tag_q[fill_idx]  <= fill_tag;
         data_q[fill_idx] <= refill_rsp.rdata;
      end
   end

   always_comb begin
      refill_req.valid = (state_q == fetch_pkg::IC_REFILL);
      refill_req.we    = 1'b0;
      refill_req.addr  = refill_addr_q;
      refill_req.wdata = '0;
   end

   refill_held: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req.valid && !refill_rsp.done |=> refill_req.valid);

endmodule

`default_nettype wire

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "fetch_defines.svh"

module fetch_stage (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   hazard,
   input  logic                   nop_req,
   input  logic                   halt,
   input  fetch_pkg::redirect_t   redirect,
   input  logic                   ic_hit,
   input  logic [`FETCH_XLEN-1:0] ic_word,
   output logic [`FETCH_XLEN-1:0] pc,
   output fetch_pkg::fetch_out_t  fetch_out
);

   logic [`FETCH_XLEN-1:0] pc_q;
   logic [`FETCH_XLEN-1:0] pc_plus2;
   logic [`FETCH_XLEN-1:0] base_target;
   logic [`FETCH_XLEN-1:0] ji_target;
   logic [`FETCH_XLEN-1:0] redir_target;
   logic [`FETCH_XLEN-1:0] pc_next;
   logic                   misaligned;
   logic                   stall;

   assign pc_plus2 = pc_q + `FETCH_XLEN'(2);

   // branch and register jump share one base + offset adder
   assign base_target = redirect.base + redirect.offset;
   assign ji_target   = pc_plus2 + redirect.offset;

   assign misaligned = pc_q[0];

   // odd pc never waits on the cache
   assign stall = ~ic_hit & ~misaligned;

   always_comb begin
      case (redirect.kind)
         fetch_pkg::REDIR_BRANCH,
         fetch_pkg::REDIR_JUMP_REG: redir_target = base_target;
         fetch_pkg::REDIR_JUMP_IMM: redir_target = ji_target;
         default:                   redir_target = pc_plus2;
      endcase
   end

   // halt is applied as the register enable below
   always_comb begin
      if (redirect.kind != fetch_pkg::REDIR_NONE) begin
         pc_next = redir_target;
      end else if (hazard || stall) begin
         pc_next = pc_q;
      end else begin
         pc_next = pc_plus2;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc_q <= '0;
      end else if (!halt) begin
         pc_q <= pc_next;
      end
   end

   assign pc = pc_q;

   always_comb begin
      fetch_out.instr     = (nop_req || stall || misaligned) ? `FETCH_NOP : ic_word;
      fetch_out.pc_plus2  = pc_plus2;
      fetch_out.align_err = misaligned;
   end

   // a redirect or a refill must not move a halted pc
   halt_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
      halt |=> $stable(pc_q));

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

   // control-flow change requested by a later stage
   typedef enum logic [1:0] {
      REDIR_NONE,
      REDIR_BRANCH,
      REDIR_JUMP_IMM,
      REDIR_JUMP_REG
   } redirect_e;

   // base is the register value for jr, or the branch's own pc+2
   typedef struct packed {
      redirect_e   kind;
      logic [15:0] base;
      logic [15:0] offset;
   } redirect_t;

   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] pc_plus2;
      logic        align_err;
   } fetch_out_t;

   typedef struct packed {
      logic        valid;
      logic        we;
      logic [15:0] addr;
      logic [15:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic        done;
      logic [15:0] rdata;
   } mem_rsp_t;

   typedef enum logic {IC_IDLE, IC_REFILL} ic_state_e;

   typedef enum logic [1:0] {GNT_NONE, GNT_DATA, GNT_IFETCH} grant_e;

endpackage

`default_nettype wire

/* include/fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// word and byte address width
`define FETCH_XLEN 16

// 16 one-word lines in the instruction cache
`define FETCH_IDX_W 4

// main memory size in 16-bit words
`define FETCH_MEM_WORDS 1024

// cycles from the first granted cycle to the done pulse
`define FETCH_MEM_LAT 3

// instruction word inserted on stall or on request
`define FETCH_NOP 16'h0800

`endif
